// File: verilog.f
+incdir+test
design/rp_pkg.sv
design/adc_frontend.sv
design/sample_fifo.sv
design/dac_output.sv
design/axil_regs.sv
design/rp_top.sv
test/tb_top.sv

// File: Bender.yml
package:
  name: rp_scope

sources:
  - design/rp_pkg.sv
  - design/adc_frontend.sv
  - design/sample_fifo.sv
  - design/dac_output.sv
  - design/axil_regs.sv
  - design/rp_top.sv
  - target: test
    include_dirs:
      - test
    files:
      - test/tb_top.sv

// File: test/tb_checks.svh
// reference model and compare tasks, included inside tb_top; needs errors, test_errs, cur_test
`ifndef TB_CHECKS_SVH
`define TB_CHECKS_SVH

// ------------------------------
// reference model
function automatic int ref_decode(code_t c);
  int v;
  v = int'(c[ADC_W-2:0] ^ {(ADC_W-1){1'b1}});     // lower bits run downwards
  return c[ADC_W-1] ? v - 8192 : v;                // msb set means negative half
endfunction

function automatic int ref_saturate(int v);
  if (v > 8191) return 8191;
  if (v < -8192) return -8192;
  return v;
endfunction

function automatic code_t ref_encode(int v);
  logic [ADC_W-1:0] raw;
  raw = v[ADC_W-1:0];                              // two's complement bits
  return {raw[ADC_W-1], ~raw[ADC_W-2:0]};
endfunction

// expected DAC code for one ADC code under a given offset
function automatic code_t dac_model(code_t c, sample_t ofs);
  return ref_encode(ref_saturate(ref_decode(c) + int'(ofs)));
endfunction

// ------------------------------
// compare tasks
task automatic check_word(string name, logic [AXI_DW-1:0] exp, logic [AXI_DW-1:0] act);
  if (exp !== act) begin
    $display("ERROR %s: expected %h, actual %h", name, exp, act);
    errors++;
    test_errs++;
  end
endtask

task automatic check_resp(string name, logic [1:0] exp, logic [1:0] act);
  if (exp !== act) begin
    $display("ERROR %s: expected resp %0d, actual resp %0d", name, exp, act);
    errors++;
    test_errs++;
  end
endtask

task automatic check_code(string name, code_t exp, code_t act);
  if (exp !== act) begin
    $display("ERROR %s: expected code %h, actual code %h", name, exp, act);
    errors++;
    test_errs++;
  end
endtask

`endif

// File: test/tb_top.sv
// directed tests on rp_top; the ADC code changes every cycle and DAC pulses are matched to it
`timescale 1ns/1ps

module tb_top;

  import rp_pkg::*;

  localparam int RUN_CYCLES = 60 + 60 + 420 + 160 + 160;  // per-test budgets

  logic adc_clk, rst_i, dac_wrt_o;
  code_t adc_dat_i, dac_dat_o;
  logic [7:0] led_o;
  logic [AXI_AW-1:0] awaddr, araddr;
  logic [AXI_DW-1:0] wdata, rdata;
  logic [3:0] wstrb;
  logic awvalid, awready, wvalid, wready, bvalid, bready, arvalid, arready, rvalid, rready;
  logic [1:0] bresp, rresp;

  logic [31:0] code_st = 32'd32105;   // ADC code LFSR
  logic [31:0] reg_st = 32'd32105;    // register value LFSR
  code_t hist[$];                     // every code driven, in order
  int hidx, chk_left, pulses, cyc, last_wr_cyc, last_rd_cyc;
  logic anchored;
  sample_t exp_ofs;
  int errors, test_errs, n_pass, n_fail;
  string cur_test;

  `include "tb_checks.svh"

  rp_top dut (
    .adc_clk(adc_clk), .rst_i(rst_i), .adc_dat_i(adc_dat_i), .dac_dat_o(dac_dat_o),
    .dac_wrt_o(dac_wrt_o), .led_o(led_o),
    .s_axil_awaddr_i(awaddr), .s_axil_awvalid_i(awvalid), .s_axil_awready_o(awready),
    .s_axil_wdata_i(wdata), .s_axil_wstrb_i(wstrb), .s_axil_wvalid_i(wvalid),
    .s_axil_wready_o(wready), .s_axil_bresp_o(bresp), .s_axil_bvalid_o(bvalid),
    .s_axil_bready_i(bready), .s_axil_araddr_i(araddr), .s_axil_arvalid_i(arvalid),
    .s_axil_arready_o(arready), .s_axil_rdata_o(rdata), .s_axil_rresp_o(rresp),
    .s_axil_rvalid_o(rvalid), .s_axil_rready_i(rready)
  );

  initial adc_clk = 1'b0;
  always #5 adc_clk = ~adc_clk;
  always @(posedge adc_clk) cyc <= cyc + 1;   // posedge count for drop math

  // x^32 + x^22 + x^2 + x + 1, one step per bit
  function automatic logic [31:0] rand_bits(inout logic [31:0] st, input int n);
    logic [31:0] r;
    logic fb;
    r = '0;
    for (int i = 0; i < n; i++) begin
      fb = st[31] ^ st[21] ^ st[1] ^ st[0];
      st = {st[30:0], fb};
      r = {r[30:0], fb};
    end
    return r;
  endfunction

  function automatic int find_anchor(code_t c);   // newest match, offset is 0 here
    for (int i = hist.size() - 1; i >= 0; i--) begin
      if (hist[i] == c) return i;
    end
    return -1;
  endfunction

  function automatic logic [31:0] reg_addr(logic [2:0] region, logic [11:0] ofs);
    return (32'(region) << REGION_LSB) | 32'(ofs);
  endfunction

  // ------------------------------
  // ADC driver and DAC monitor
  always @(negedge adc_clk) begin : stream
    int idx;
    code_t code;
    if (dac_wrt_o) begin
      pulses <= pulses + 1;
      if (!anchored) begin
        idx = find_anchor(dac_dat_o);
        if (idx < 0) begin
          $display("test %s: DAC output not found among driven ADC codes", cur_test);
          errors++;
          test_errs++;
        end else begin
          hidx <= idx + 1;
          anchored <= 1'b1;
        end
      end else begin
        if (chk_left > 0) begin
          check_code(cur_test, dac_model(hist[hidx], exp_ofs), dac_dat_o);
          chk_left <= chk_left - 1;
        end
        hidx <= hidx + 1;               // next sample in stream order
      end
    end
    code = rand_bits(code_st, ADC_W);
    adc_dat_i <= code;
    hist.push_back(code);
  end

  // ------------------------------
  // AXI master, called on a falling edge
  task automatic axi_write(logic [31:0] addr, logic [31:0] data, logic [3:0] strb,
                           output logic [1:0] resp);
    awaddr = addr;
    wdata = data;
    wstrb = strb;
    awvalid = 1'b1;
    wvalid = 1'b1;
    while (!awready) @(negedge adc_clk);
    if (wready !== 1'b1) begin
      $display("test %s: wready did not rise together with awready", cur_test);
      errors++;
      test_errs++;
    end
    last_wr_cyc = cyc + 1;             // handshake on the coming edge
    @(negedge adc_clk);
    awvalid = 1'b0;
    wvalid = 1'b0;
    while (!bvalid) @(negedge adc_clk);
    resp = bresp;
  endtask

  task automatic axi_read(logic [31:0] addr, output logic [31:0] data, output logic [1:0] resp);
    araddr = addr;
    arvalid = 1'b1;
    while (!arready) @(negedge adc_clk);
    last_rd_cyc = cyc + 1;
    @(negedge adc_clk);
    arvalid = 1'b0;
    while (!rvalid) @(negedge adc_clk);
    data = rdata;
    resp = rresp;
  endtask

  task automatic write_ok(logic [2:0] region, logic [11:0] ofs, logic [31:0] data);
    logic [1:0] r;
    axi_write(reg_addr(region, ofs), data, 4'hf, r);
    check_resp({cur_test, " write"}, RESP_OKAY, r);
  endtask

  task automatic read_check(logic [2:0] region, logic [11:0] ofs, logic [31:0] exp,
                            logic [1:0] exp_resp);
    logic [31:0] d;
    logic [1:0] r;
    axi_read(reg_addr(region, ofs), d, r);
    check_resp(cur_test, exp_resp, r);
    check_word(cur_test, exp, d);
  endtask

  task automatic wait_checked();      // until the monitor used up chk_left
    do @(negedge adc_clk); while (chk_left != 0);
  endtask

  task automatic finish_test();
    if (test_errs == 0) begin
      $display("test %s: passed", cur_test);
      n_pass++;
    end else begin
      $display("test %s: failed with %0d errors", cur_test, test_errs);
      n_fail++;
    end
    test_errs = 0;
  endtask

  // ------------------------------
  // directed tests
  task automatic test_regs();
    logic [31:0] v;
    logic [1:0] r;
    cur_test = "regs";
    read_check(REG_HK, OFS_ID, RP_ID, RESP_OKAY);
    v = rand_bits(reg_st, 32);
    axi_write(reg_addr(REG_HK, OFS_LED), v, 4'b0001, r);
    check_resp("regs write", RESP_OKAY, r);
    axi_write(reg_addr(REG_HK, OFS_LED), ~v, 4'b1110, r);   // no byte 0, LED holds
    check_resp("regs write", RESP_OKAY, r);
    read_check(REG_HK, OFS_LED, {24'h0, v[7:0]}, RESP_OKAY);
    check_word("regs led_o", {24'h0, v[7:0]}, {24'h0, led_o});
    finish_test();
  endtask

  task automatic test_unmapped();
    logic [1:0] r;
    cur_test = "unmapped";
    read_check(3'd3, 12'h000, 32'h0, RESP_SLVERR);
    axi_write(reg_addr(3'd5, 12'h004), rand_bits(reg_st, 32), 4'hf, r);
    check_resp("unmapped write", RESP_SLVERR, r);
    read_check(REG_SIG, 12'h010, 32'h0, RESP_OKAY);          // hole in a mapped region
    write_ok(REG_HK, 12'h020, rand_bits(reg_st, 32));
    finish_test();
  endtask

  task automatic test_offsets();
    int ofs_list[6];
    cur_test = "offsets";
    ofs_list = '{0, 8000, -8000, 8191, -8192, 0};
    ofs_list[5] = int'($signed(rand_bits(reg_st, ADC_W))) >>> 1;
    write_ok(REG_SIG, OFS_CTRL, 32'h1);
    repeat (FIFO_DEPTH + 4) @(negedge adc_clk);  // samples held since reset drain
    anchored <= 1'b0;                   // drops before enable broke the run
    foreach (ofs_list[i]) begin
      write_ok(REG_SIG, OFS_DAC_OFFSET, 32'(ofs_list[i]));
      repeat (4) @(negedge adc_clk);    // offset settles, stream anchors
      exp_ofs <= sample_t'(ofs_list[i]);
      chk_left <= 40;
      wait_checked();
    end
    write_ok(REG_SIG, OFS_DAC_OFFSET, 32'h0);
    repeat (4) @(negedge adc_clk);
    exp_ofs <= '0;
    finish_test();
  endtask

  task automatic test_buffer();
    int p0;
    cur_test = "buffer";
    write_ok(REG_SIG, OFS_CTRL, 32'h0);
    @(negedge adc_clk);
    p0 = pulses;
    repeat (24) @(negedge adc_clk);
    if (pulses != p0) begin
      $display("test %s: dac_wrt_o pulsed while the output was disabled", cur_test);
      errors++;
      test_errs++;
    end
    read_check(REG_SIG, OFS_LEVEL, FIFO_DEPTH, RESP_OKAY);
    chk_left <= FIFO_DEPTH;             // buffered run continues the stream
    write_ok(REG_SIG, OFS_CTRL, 32'h1);
    wait_checked();
    anchored <= 1'b0;                   // drops broke the run
    finish_test();
  endtask

  task automatic test_drops();
    logic [31:0] d;
    logic [1:0] r;
    cur_test = "drops";
    write_ok(REG_SIG, OFS_CTRL, 32'h0);
    repeat (24) @(negedge adc_clk);     // FIFO full, one drop per cycle
    read_check(REG_SIG, OFS_LEVEL, FIFO_DEPTH, RESP_OKAY);
    write_ok(REG_SIG, OFS_DROPS, 32'h0);
    axi_read(reg_addr(REG_SIG, OFS_DROPS), d, r);
    check_resp(cur_test, RESP_OKAY, r);
    check_word(cur_test, 32'(last_rd_cyc - last_wr_cyc - 1), d);
    write_ok(REG_SIG, OFS_CTRL, 32'h1);
    repeat (24) @(negedge adc_clk);     // draining, no more drops
    write_ok(REG_SIG, OFS_DROPS, 32'h0);
    read_check(REG_SIG, OFS_DROPS, 32'h0, RESP_OKAY);
    finish_test();
  endtask

  // ------------------------------
  // watchdog and main sequence
  initial begin
    #(RUN_CYCLES * 10 * 2);
    $display("timeout: tests did not finish in %0d cycles", RUN_CYCLES * 2);
    $display("** FAIL **");
    $finish;
  end

  initial begin
    {awaddr, araddr, wdata, wstrb, awvalid, wvalid, arvalid} = '0;
    bready = 1'b1;
    rready = 1'b1;
    adc_dat_i = '0;
    {hidx, chk_left, pulses, cyc, errors, test_errs, n_pass, n_fail} = '0;
    anchored = 1'b0;
    exp_ofs = '0;
    cur_test = "reset";
    rst_i = 1'b1;
    repeat (4) @(negedge adc_clk);
    rst_i = 1'b0;
    test_regs();
    test_unmapped();
    test_offsets();
    test_buffer();
    test_drops();
    $display("%0d tests passed, %0d failed, %0d errors", n_pass, n_fail, errors);
    if (n_fail == 0 && errors == 0) begin
      $display("** PASS **");
    end else begin
      $display("** FAIL **");
    end
    $finish;
  end

endmodule

// File: design/rp_top.sv
// one channel only, everything on adc_clk; the AXI master must share that clock
`timescale 1ns/1ps

module rp_top (
  input  logic                      adc_clk,
  input  logic                      rst_i,
  input  rp_pkg::code_t             adc_dat_i,          // ADC pins
  output rp_pkg::code_t             dac_dat_o,          // DAC pins
  output logic                      dac_wrt_o,
  output logic [7:0]                led_o,
  input  logic [rp_pkg::AXI_AW-1:0] s_axil_awaddr_i,
  input  logic                      s_axil_awvalid_i,
  output logic                      s_axil_awready_o,
  input  logic [rp_pkg::AXI_DW-1:0] s_axil_wdata_i,
  input  logic [3:0]                s_axil_wstrb_i,
  input  logic                      s_axil_wvalid_i,
  output logic                      s_axil_wready_o,
  output logic [1:0]                s_axil_bresp_o,
  output logic                      s_axil_bvalid_o,
  input  logic                      s_axil_bready_i,
  input  logic [rp_pkg::AXI_AW-1:0] s_axil_araddr_i,
  input  logic                      s_axil_arvalid_i,
  output logic                      s_axil_arready_o,
  output logic [rp_pkg::AXI_DW-1:0] s_axil_rdata_o,
  output logic [1:0]                s_axil_rresp_o,
  output logic                      s_axil_rvalid_o,
  input  logic                      s_axil_rready_i
);

  import rp_pkg::*;

  logic             adc_valid;      // frontend to FIFO
  sample_t          adc_sample;
  logic             rd_valid;       // FIFO to DAC stage
  sample_t          rd_data;
  logic             rd_pop;
  logic [LVL_W-1:0] level;          // status to registers
  logic [31:0]      drops;
  logic             drops_clear;
  logic             dac_enable;     // registers to DAC stage
  sample_t          dac_offset;

  // ------------------------------
  // analog path
  adc_frontend i_adc (
    .adc_clk        (adc_clk),
    .rst_i          (rst_i),
    .adc_dat_i      (adc_dat_i),
    .sample_valid_o (adc_valid),
    .sample_o       (adc_sample)
  );

  sample_fifo #(.DEPTH(FIFO_DEPTH)) i_fifo (
    .adc_clk       (adc_clk),
    .rst_i         (rst_i),
    .wr_valid_i    (adc_valid),
    .wr_data_i     (adc_sample),
    .rd_valid_o    (rd_valid),
    .rd_data_o     (rd_data),
    .rd_pop_i      (rd_pop),
    .level_o       (level),
    .drops_o       (drops),
    .drops_clear_i (drops_clear)
  );

  dac_output i_dac (
    .adc_clk      (adc_clk),
    .rst_i        (rst_i),
    .dac_enable_i (dac_enable),
    .dac_offset_i (dac_offset),
    .rd_valid_i   (rd_valid),
    .rd_data_i    (rd_data),
    .rd_pop_o     (rd_pop),
    .dac_dat_o    (dac_dat_o),
    .dac_wrt_o    (dac_wrt_o)
  );

  // ------------------------------
  // register access
  axil_regs i_regs (
    .adc_clk          (adc_clk),
    .rst_i            (rst_i),
    .s_axil_awaddr_i  (s_axil_awaddr_i),
    .s_axil_awvalid_i (s_axil_awvalid_i),
    .s_axil_awready_o (s_axil_awready_o),
    .s_axil_wdata_i   (s_axil_wdata_i),
    .s_axil_wstrb_i   (s_axil_wstrb_i),
    .s_axil_wvalid_i  (s_axil_wvalid_i),
    .s_axil_wready_o  (s_axil_wready_o),
    .s_axil_bresp_o   (s_axil_bresp_o),
    .s_axil_bvalid_o  (s_axil_bvalid_o),
    .s_axil_bready_i  (s_axil_bready_i),
    .s_axil_araddr_i  (s_axil_araddr_i),
    .s_axil_arvalid_i (s_axil_arvalid_i),
    .s_axil_arready_o (s_axil_arready_o),
    .s_axil_rdata_o   (s_axil_rdata_o),
    .s_axil_rresp_o   (s_axil_rresp_o),
    .s_axil_rvalid_o  (s_axil_rvalid_o),
    .s_axil_rready_i  (s_axil_rready_i),
    .led_o            (led_o),
    .dac_enable_o     (dac_enable),
    .dac_offset_o     (dac_offset),
    .level_i          (level),
    .drops_i          (drops),
    .drops_clear_o    (drops_clear)
  );

endmodule

// File: design/axil_regs.sv
// single outstanding AXI4-Lite transaction per channel; only regions 0 and 1 are mapped, others SLVERR
`timescale 1ns/1ps

module axil_regs (
  input  logic                      adc_clk,
  input  logic                      rst_i,
  // write address and data
  input  logic [rp_pkg::AXI_AW-1:0] s_axil_awaddr_i,
  input  logic                      s_axil_awvalid_i,
  output logic                      s_axil_awready_o,
  input  logic [rp_pkg::AXI_DW-1:0] s_axil_wdata_i,
  input  logic [3:0]                s_axil_wstrb_i,
  input  logic                      s_axil_wvalid_i,
  output logic                      s_axil_wready_o,
  // write response
  output logic [1:0]                s_axil_bresp_o,
  output logic                      s_axil_bvalid_o,
  input  logic                      s_axil_bready_i,
  // read address and data
  input  logic [rp_pkg::AXI_AW-1:0] s_axil_araddr_i,
  input  logic                      s_axil_arvalid_i,
  output logic                      s_axil_arready_o,
  output logic [rp_pkg::AXI_DW-1:0] s_axil_rdata_o,
  output logic [1:0]                s_axil_rresp_o,
  output logic                      s_axil_rvalid_o,
  input  logic                      s_axil_rready_i,
  // register fields
  output logic [7:0]                led_o,
  output logic                      dac_enable_o,
  output rp_pkg::sample_t           dac_offset_o,
  input  logic [rp_pkg::LVL_W-1:0]  level_i,
  input  logic [31:0]               drops_i,
  output logic                      drops_clear_o
);

  import rp_pkg::*;

  logic [2:0]        wr_region;
  logic [2:0]        rd_region;
  logic [11:0]       wr_ofs;
  logic [11:0]       rd_ofs;
  logic [7:0]        wr_cs;            // one-hot region select
  logic [7:0]        rd_cs;
  logic              wr_hk;
  logic              wr_sig;
  logic              rd_hk;
  logic              rd_sig;
  logic              wr_en;            // write handshake cycle
  logic              rd_en;            // read handshake cycle
  logic [AXI_DW-1:0] rd_mux;

  // ------------------------------
  // region decoder, 8 regions
  assign wr_region = s_axil_awaddr_i[REGION_LSB+2:REGION_LSB];
  assign rd_region = s_axil_araddr_i[REGION_LSB+2:REGION_LSB];
  assign wr_ofs    = s_axil_awaddr_i[11:0];
  assign rd_ofs    = s_axil_araddr_i[11:0];
  assign wr_cs     = 8'b1 << wr_region;
  assign rd_cs     = 8'b1 << rd_region;
  assign wr_hk     = wr_cs[REG_HK];
  assign wr_sig    = wr_cs[REG_SIG];
  assign rd_hk     = rd_cs[REG_HK];
  assign rd_sig    = rd_cs[REG_SIG];

  // ------------------------------
  // write channel
  assign s_axil_wready_o = s_axil_awready_o;   // address and data taken together
  assign wr_en = s_axil_awready_o & s_axil_awvalid_i & s_axil_wvalid_i;

  always_ff @(posedge adc_clk) begin
    if (rst_i) begin
      s_axil_awready_o <= 1'b0;
      s_axil_bvalid_o  <= 1'b0;
    end else begin
      // one-cycle ready once both valids are up and no response is waiting
      s_axil_awready_o <= s_axil_awvalid_i & s_axil_wvalid_i
                        & ~s_axil_awready_o & ~s_axil_bvalid_o;
      if (wr_en) begin
        s_axil_bvalid_o <= 1'b1;
      end else if (s_axil_bready_i) begin
        s_axil_bvalid_o <= 1'b0;               // response accepted
      end
    end
  end

  always_ff @(posedge adc_clk) begin
    if (wr_en) begin
      s_axil_bresp_o <= (wr_hk | wr_sig) ? RESP_OKAY : RESP_SLVERR;
    end
  end

  // register file, updated at the end of the handshake cycle
  always_ff @(posedge adc_clk) begin
    if (rst_i) begin
      led_o        <= '0;
      dac_enable_o <= 1'b0;
      dac_offset_o <= '0;
    end else if (wr_en) begin
      if (wr_hk && wr_ofs == OFS_LED && s_axil_wstrb_i[0]) begin
        led_o <= s_axil_wdata_i[7:0];
      end
      if (wr_sig && wr_ofs == OFS_CTRL && s_axil_wstrb_i[0]) begin
        dac_enable_o <= s_axil_wdata_i[0];
      end
      if (wr_sig && wr_ofs == OFS_DAC_OFFSET) begin
        if (s_axil_wstrb_i[0]) dac_offset_o[7:0]       <= s_axil_wdata_i[7:0];
        if (s_axil_wstrb_i[1]) dac_offset_o[ADC_W-1:8] <= s_axil_wdata_i[ADC_W-1:8];
      end
    end
  end

  // counter clears the cycle after the handshake
  assign drops_clear_o = wr_en & wr_sig & (wr_ofs == OFS_DROPS);

  // ------------------------------
  // read channel
  assign rd_en = s_axil_arready_o & s_axil_arvalid_i;

  always_comb begin
    rd_mux = '0;                               // unmapped and unlisted read 0
    if (rd_hk) begin
      case (rd_ofs)
        OFS_ID:  rd_mux = RP_ID;
        OFS_LED: rd_mux = {{(AXI_DW-8){1'b0}}, led_o};
        default: rd_mux = '0;
      endcase
    end else if (rd_sig) begin
      case (rd_ofs)
        OFS_CTRL:       rd_mux = {{(AXI_DW-1){1'b0}}, dac_enable_o};
        OFS_DAC_OFFSET: rd_mux = {{(AXI_DW-ADC_W){dac_offset_o[ADC_W-1]}}, dac_offset_o};
        OFS_LEVEL:      rd_mux = {{(AXI_DW-LVL_W){1'b0}}, level_i};
        OFS_DROPS:      rd_mux = drops_i;
        default:        rd_mux = '0;
      endcase
    end
  end

  always_ff @(posedge adc_clk) begin
    if (rst_i) begin
      s_axil_arready_o <= 1'b0;
      s_axil_rvalid_o  <= 1'b0;
    end else begin
      s_axil_arready_o <= s_axil_arvalid_i & ~s_axil_arready_o & ~s_axil_rvalid_o;
      if (rd_en) begin
        s_axil_rvalid_o <= 1'b1;
      end else if (s_axil_rready_i) begin
        s_axil_rvalid_o <= 1'b0;
      end
    end
  end

  // data and response held until rready
  always_ff @(posedge adc_clk) begin
    if (rd_en) begin
      s_axil_rdata_o <= rd_mux;
      s_axil_rresp_o <= (rd_hk | rd_sig) ? RESP_OKAY : RESP_SLVERR;
    end
  end

endmodule

// File: design/dac_output.sv
// pops only while enabled; the offset sum saturates to the 14-bit range before encoding
`timescale 1ns/1ps

module dac_output (
  input  logic            adc_clk,
  input  logic            rst_i,
  input  logic            dac_enable_i,    // from CTRL bit 0
  input  rp_pkg::sample_t dac_offset_i,    // signed offset
  input  logic            rd_valid_i,      // FIFO head present
  input  rp_pkg::sample_t rd_data_i,       // FIFO head
  output logic            rd_pop_o,
  output rp_pkg::code_t   dac_dat_o,       // DAC code, neg slope
  output logic            dac_wrt_o        // one pulse per sample
);

  import rp_pkg::*;

  logic signed [ADC_W:0] sum;              // one guard bit
  sample_t               sat;

  // back-pressure: samples stay in the FIFO while disabled
  assign rd_pop_o = dac_enable_i & rd_valid_i;

  // ------------------------------
  // sum and saturation
  assign sum = {rd_data_i[ADC_W-1], rd_data_i}
             + {dac_offset_i[ADC_W-1], dac_offset_i};

  always_comb begin
    case (sum[ADC_W:ADC_W-1])
      2'b01:   sat = {1'b0, {(ADC_W-1){1'b1}}};  // pos overflow, +8191
      2'b10:   sat = {1'b1, {(ADC_W-1){1'b0}}};  // neg overflow, -8192
      default: sat = sum[ADC_W-1:0];             // in range
    endcase
  end

  // ------------------------------
  // output register

  // code and strobe leave together, one cycle after the pop
  always_ff @(posedge adc_clk) begin
    if (rst_i) begin
      dac_wrt_o <= 1'b0;
      dac_dat_o <= to_code(sample_t'(0));  // mid-scale
    end else begin
      dac_wrt_o <= rd_pop_o;
      if (rd_pop_o) begin
        dac_dat_o <= to_code(sat);         // hold last code otherwise
      end
    end
  end

endmodule

// File: design/sample_fifo.sv
// DEPTH must be a power of two; pushes while full are dropped and counted, the producer never waits
`timescale 1ns/1ps

module sample_fifo #(
  parameter int DEPTH = rp_pkg::FIFO_DEPTH
) (
  input  logic                   adc_clk,
  input  logic                   rst_i,
  input  logic                   wr_valid_i,     // push request
  input  rp_pkg::sample_t        wr_data_i,
  output logic                   rd_valid_o,     // head entry present
  output rp_pkg::sample_t        rd_data_o,      // head entry, show-ahead
  input  logic                   rd_pop_i,       // consume head
  output logic [$clog2(DEPTH):0] level_o,        // stored entries
  output logic [31:0]            drops_o,        // saturating drop count
  input  logic                   drops_clear_i   // one-cycle clear
);

  import rp_pkg::*;

  sample_t                  mem [DEPTH];         // storage array
  logic [$clog2(DEPTH)-1:0] wr_ptr;
  logic [$clog2(DEPTH)-1:0] rd_ptr;
  logic [$clog2(DEPTH):0]   count;
  logic                     full;
  logic                     do_push;
  logic                     do_pop;
  logic                     do_drop;

  assign full    = (count == ($clog2(DEPTH) + 1)'(DEPTH));
  assign do_push = wr_valid_i & ~full;
  assign do_drop = wr_valid_i & full;            // discarded sample
  assign do_pop  = rd_pop_i & rd_valid_o;        // ignore pop on empty

  // ------------------------------
  // storage and pointers
  always_ff @(posedge adc_clk) begin
    if (do_push) begin
      mem[wr_ptr] <= wr_data_i;
    end
  end

  always_ff @(posedge adc_clk) begin
    if (rst_i) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (do_push) wr_ptr <= wr_ptr + 1'b1;      // wraps at DEPTH
      if (do_pop)  rd_ptr <= rd_ptr + 1'b1;
      case ({do_push, do_pop})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;                 // both or neither
      endcase
    end
  end

  // head is read straight from the array, so a push shows up next cycle
  assign rd_valid_o = (count != '0);
  assign rd_data_o  = mem[rd_ptr];
  assign level_o    = count;

  // ------------------------------
  // drop counter
  always_ff @(posedge adc_clk) begin
    if (rst_i) begin
      drops_o <= '0;
    end else if (drops_clear_i) begin
      drops_o <= '0;                             // clear wins over a drop
    end else if (do_drop && drops_o != '1) begin
      drops_o <= drops_o + 1'b1;                 // sticks at max
    end
  end

endmodule

// File: design/adc_frontend.sv
// expects a free-running ADC on adc_clk; one sample per cycle, no decimation and no dither
`timescale 1ns/1ps

module adc_frontend (
  input  logic            adc_clk,
  input  logic            rst_i,
  input  rp_pkg::code_t   adc_dat_i,       // raw code, negative slope
  output logic            sample_valid_o,  // high every cycle out of reset
  output rp_pkg::sample_t sample_o         // two's complement
);

  import rp_pkg::*;

  code_t code_q;                           // input capture stage

  // ------------------------------
  // capture and convert

  // converter output lands here first
  always_ff @(posedge adc_clk) begin
    code_q <= adc_dat_i;                   // no reset on data
  end

  // sample lines up with code_q one cycle after the pins
  assign sample_o = to_sample(code_q);     // flip lower bits, keep sign

  always_ff @(posedge adc_clk) begin
    if (rst_i) begin
      sample_valid_o <= 1'b0;              // nothing offered in reset
    end else begin
      sample_valid_o <= 1'b1;              // streaming from now on
    end
  end

endmodule

// File: design/rp_pkg.sv
// widths, register map and code conversion for one analog channel; ADC_W is shared by ADC and DAC
package rp_pkg;

  // ------------------------------
  // converter and sample format
  localparam int ADC_W = 14;                       // ADC and DAC code width

  typedef logic signed [ADC_W-1:0] sample_t;       // two's complement sample
  typedef logic        [ADC_W-1:0] code_t;         // raw converter code, neg slope

  // ------------------------------
  // bus widths and region decode
  localparam int AXI_AW     = 32;
  localparam int AXI_DW     = 32;
  localparam int REGION_LSB = 20;                  // region field is addr[22:20]

  localparam logic [2:0] REG_HK  = 3'd0;           // housekeeping
  localparam logic [2:0] REG_SIG = 3'd1;           // signal path

  // offsets inside a region
  localparam logic [11:0] OFS_ID         = 12'h000; // hk, read only
  localparam logic [11:0] OFS_LED        = 12'h004; // hk
  localparam logic [11:0] OFS_CTRL       = 12'h000; // sig, bit 0 enable
  localparam logic [11:0] OFS_DAC_OFFSET = 12'h004; // sig, signed
  localparam logic [11:0] OFS_LEVEL      = 12'h008; // sig, read only
  localparam logic [11:0] OFS_DROPS      = 12'h00C; // sig, write clears

  localparam logic [31:0] RP_ID = 32'h5250_0001;

  // ------------------------------
  // buffer sizing and responses
  localparam int FIFO_DEPTH = 16;
  localparam int LVL_W      = $clog2(FIFO_DEPTH) + 1; // holds 0..FIFO_DEPTH

  localparam logic [1:0] RESP_OKAY   = 2'd0;
  localparam logic [1:0] RESP_SLVERR = 2'd2;

  // msb kept, lower bits inverted; the same flip works in both directions
  function automatic sample_t to_sample(code_t c);
    return {c[ADC_W-1], ~c[ADC_W-2:0]};
  endfunction

  function automatic code_t to_code(sample_t s);
    return {s[ADC_W-1], ~s[ADC_W-2:0]};
  endfunction

endpackage
